// File: decode_pkg.sv
`default_nettype none

package decode_pkg;

  ////////////////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////////////////

  localparam int xlen           = 32;
  localparam int pc_width       = 16;
  localparam int reg_addr_width = 5;

  // IF/ID buffering between fetch and decode
  localparam int queue_depth    = 4;

  ////////////////////////////////////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////////////////////////////////////

  // RV32I major opcodes in bits [6:0] of the word
  typedef enum logic [6:0] {
    opc_load   = 7'b0000011,
    opc_op_imm = 7'b0010011,
    opc_auipc  = 7'b0010111,
    opc_store  = 7'b0100011,
    opc_op     = 7'b0110011,
    opc_lui    = 7'b0110111,
    opc_branch = 7'b1100011,
    opc_jalr   = 7'b1100111,
    opc_jal    = 7'b1101111
  } opcode_e;

  // Instruction class handed to execute
  typedef enum logic [3:0] {
    op_alu_reg,
    op_alu_imm,
    op_load,
    op_store,
    op_branch,
    op_jal,
    op_jalr,
    op_lui,
    op_auipc,
    op_illegal
  } op_class_e;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and
  } alu_op_e;

  // Four-phase handshake states shared by both boundaries
  typedef enum logic [1:0] {
    hs_idle,
    hs_wait_ack_high,
    hs_wait_ack_low
  } hs_state_e;

endpackage

`default_nettype wire

// File: if_id_if.sv
`default_nettype none

// One IF/ID word link
// Transfer on each edge with valid and ready both high
interface if_id_if;

  logic                              valid;
  logic                              ready;
  logic [decode_pkg::pc_width-1:0]   pc;
  logic [31:0]                       ins;

  // Producer side holds pc and ins while stalled
  modport src (
    output valid,
    output pc,
    output ins,
    input  ready
  );

  // Consumer side
  modport dst (
    input  valid,
    input  pc,
    input  ins,
    output ready
  );

endinterface

`default_nettype wire

// File: fetch_receiver.sv
`default_nettype none

module fetch_receiver (
  input  logic                            bus,
  input  logic                            arst_n,
  input  logic                            fetch_req,
  input  logic [decode_pkg::pc_width-1:0] fetch_pc,
  input  logic [31:0]                     fetch_ins,
  output logic                            fetch_ack,
  if_id_if.src                            link
);

  decode_pkg::hs_state_e state;

  logic [decode_pkg::pc_width-1:0] pc_q;
  logic [31:0]                     ins_q;

  //////////////////////////////////////////////////////////////////////
  // Handshake FSM
  //////////////////////////////////////////////////////////////////////

  // hs_wait_ack_high holds the word on the link until the queue takes it,
  // hs_wait_ack_low keeps ack up until the requester lets go of req
  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      state <= decode_pkg::hs_idle;
    end else begin
      unique case (state)
        decode_pkg::hs_idle: begin
          if (fetch_req) begin
            state <= decode_pkg::hs_wait_ack_high;
          end
        end
        decode_pkg::hs_wait_ack_high: begin
          if (link.ready) begin
            state <= decode_pkg::hs_wait_ack_low;
          end
        end
        decode_pkg::hs_wait_ack_low: begin
          if (!fetch_req) begin
            state <= decode_pkg::hs_idle;
          end
        end
        default: state <= decode_pkg::hs_idle;
      endcase
    end
  end

  // Capture word on request
  always_ff @(posedge bus) begin
    if (state == decode_pkg::hs_idle && fetch_req) begin
      pc_q  <= fetch_pc;
      ins_q <= fetch_ins;
    end
  end

  assign link.valid = (state == decode_pkg::hs_wait_ack_high);
  assign link.pc    = pc_q;
  assign link.ins   = ins_q;

  // Ack only once the word sits in the queue
  assign fetch_ack  = (state == decode_pkg::hs_wait_ack_low);

  a_ack_needs_req : assert property (
    @(posedge bus) disable iff (!arst_n)
    $rose(fetch_ack) |-> fetch_req
  );

endmodule

`default_nettype wire

// File: if_id_queue.sv
`default_nettype none

module if_id_queue (
  input  logic bus,
  input  logic arst_n,
  if_id_if.dst wr,
  if_id_if.src rd
);

  localparam int ptr_width = $clog2(decode_pkg::queue_depth);

  logic [decode_pkg::pc_width-1:0] pc_mem  [decode_pkg::queue_depth];
  logic [31:0]                     ins_mem [decode_pkg::queue_depth];

  logic [ptr_width-1:0] wr_ptr;
  logic [ptr_width-1:0] rd_ptr;
  logic [ptr_width:0]   count;

  logic full;
  logic empty;
  logic push;
  logic pop;

  assign full  = (count == decode_pkg::queue_depth);
  assign empty = (count == '0);
  assign push  = wr.valid && wr.ready;
  assign pop   = rd.valid && rd.ready;

  //////////////////////////////////////////////////////////////////////
  // Pointers and fill level
  //////////////////////////////////////////////////////////////////////

  // Depth is a power of two so the pointers wrap on their own
  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge bus) begin
    if (push) begin
      pc_mem[wr_ptr]  <= wr.pc;
      ins_mem[wr_ptr] <= wr.ins;
    end
  end

  assign wr.ready = !full;
  // Word written this cycle shows up only after the edge
  assign rd.valid = !empty;
  assign rd.pc    = pc_mem[rd_ptr];
  assign rd.ins   = ins_mem[rd_ptr];

  a_count_bound : assert property (
    @(posedge bus) disable iff (!arst_n)
    count <= decode_pkg::queue_depth
  );

  // Stalled producer must hold its word
  a_wr_hold : assert property (
    @(posedge bus) disable iff (!arst_n)
    (wr.valid && !wr.ready) |=> (wr.valid && $stable(wr.pc) && $stable(wr.ins))
  );

endmodule

`default_nettype wire

// File: reg_file.sv
`default_nettype none

module reg_file (
  input  logic                                  bus,
  input  logic                                  arst_n,
  input  logic [decode_pkg::reg_addr_width-1:0] rs1,
  input  logic [decode_pkg::reg_addr_width-1:0] rs2,
  output logic [decode_pkg::xlen-1:0]           rs1_val,
  output logic [decode_pkg::xlen-1:0]           rs2_val,
  input  logic                                  wr_en,
  input  logic [decode_pkg::reg_addr_width-1:0] wr_rd,
  input  logic [decode_pkg::xlen-1:0]           wr_data
);

  logic [decode_pkg::xlen-1:0] regs [2**decode_pkg::reg_addr_width];

  // Writes to x0 dropped
  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < 2**decode_pkg::reg_addr_width; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && (wr_rd != '0)) begin
      regs[wr_rd] <= wr_data;
    end
  end

  // Combinational reads without write bypass
  assign rs1_val = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_val = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// File: decode_stage.sv
`default_nettype none

module decode_stage (
  input  logic                                  bus,
  input  logic                                  arst_n,
  if_id_if.dst                                  link,
  input  logic                                  wb_en,
  input  logic [decode_pkg::reg_addr_width-1:0] wb_rd,
  input  logic [decode_pkg::xlen-1:0]           wb_data,
  output logic                                  ex_req,
  input  logic                                  ex_ack,
  output decode_pkg::op_class_e                 ex_op,
  output decode_pkg::alu_op_e                   ex_alu,
  output logic [decode_pkg::reg_addr_width-1:0] ex_rd,
  output logic [decode_pkg::xlen-1:0]           ex_rs1_val,
  output logic [decode_pkg::xlen-1:0]           ex_rs2_val,
  output logic [decode_pkg::xlen-1:0]           ex_imm,
  output logic [decode_pkg::pc_width-1:0]       ex_pc,
  output logic                                  ex_regwrite,
  output logic                                  ex_branch_taken
);

  decode_pkg::hs_state_e state;
  decode_pkg::opcode_e   opcode;
  decode_pkg::op_class_e op_class;
  decode_pkg::alu_op_e   alu_op;

  logic [2:0]                  funct3;
  logic [decode_pkg::xlen-1:0] rs1_val;
  logic [decode_pkg::xlen-1:0] rs2_val;
  logic [decode_pkg::xlen-1:0] imm;
  logic                        cond_true;
  logic                        taken;
  logic                        regwrite;
  logic                        pop;

  reg_file rf_i (
    .bus     (bus),
    .arst_n  (arst_n),
    .rs1     (link.ins[19:15]),
    .rs2     (link.ins[24:20]),
    .rs1_val (rs1_val),
    .rs2_val (rs2_val),
    .wr_en   (wb_en),
    .wr_rd   (wb_rd),
    .wr_data (wb_data)
  );

  // alt is bit 30 of the word; immediate ADDI has no SUB form
  function automatic decode_pkg::alu_op_e alu_of(input logic [2:0] f3, input logic alt);
    unique case (f3)
      3'd0:    return alt ? decode_pkg::alu_sub : decode_pkg::alu_add;
      3'd1:    return decode_pkg::alu_sll;
      3'd2:    return decode_pkg::alu_slt;
      3'd3:    return decode_pkg::alu_sltu;
      3'd4:    return decode_pkg::alu_xor;
      3'd5:    return alt ? decode_pkg::alu_sra : decode_pkg::alu_srl;
      3'd6:    return decode_pkg::alu_or;
      default: return decode_pkg::alu_and;
    endcase
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Class, ALU operation and immediate
  //////////////////////////////////////////////////////////////////////

  assign opcode = decode_pkg::opcode_e'(link.ins[6:0]);
  assign funct3 = link.ins[14:12];

  always_comb begin
    op_class = decode_pkg::op_illegal;
    alu_op   = decode_pkg::alu_add;
    imm      = '0;
    case (opcode)
      decode_pkg::opc_op: begin
        op_class = decode_pkg::op_alu_reg;
        alu_op   = alu_of(funct3, link.ins[30]);
      end
      decode_pkg::opc_op_imm: begin
        op_class = decode_pkg::op_alu_imm;
        alu_op   = alu_of(funct3, link.ins[30] && (funct3 == 3'd5));
        imm      = {{20{link.ins[31]}}, link.ins[31:20]};
      end
      decode_pkg::opc_load: begin
        op_class = decode_pkg::op_load;
        imm      = {{20{link.ins[31]}}, link.ins[31:20]};
      end
      decode_pkg::opc_store: begin
        op_class = decode_pkg::op_store;
        imm      = {{20{link.ins[31]}}, link.ins[31:25], link.ins[11:7]};
      end
      decode_pkg::opc_branch: begin
        op_class = decode_pkg::op_branch;
        alu_op   = decode_pkg::alu_sub;
        imm      = {{19{link.ins[31]}}, link.ins[31], link.ins[7],
                    link.ins[30:25], link.ins[11:8], 1'b0};
      end
      decode_pkg::opc_jal: begin
        op_class = decode_pkg::op_jal;
        imm      = {{11{link.ins[31]}}, link.ins[31], link.ins[19:12],
                    link.ins[20], link.ins[30:21], 1'b0};
      end
      decode_pkg::opc_jalr: begin
        op_class = decode_pkg::op_jalr;
        imm      = {{20{link.ins[31]}}, link.ins[31:20]};
      end
      decode_pkg::opc_lui: begin
        op_class = decode_pkg::op_lui;
        imm      = {link.ins[31:12], 12'b0};
      end
      decode_pkg::opc_auipc: begin
        op_class = decode_pkg::op_auipc;
        imm      = {link.ins[31:12], 12'b0};
      end
      default: ;
    endcase
  end

  // Early branch resolution on the raw register values
  always_comb begin
    unique case (funct3)
      3'b000:  cond_true = (rs1_val == rs2_val);
      3'b001:  cond_true = (rs1_val != rs2_val);
      3'b100:  cond_true = ($signed(rs1_val) < $signed(rs2_val));
      3'b101:  cond_true = ($signed(rs1_val) >= $signed(rs2_val));
      3'b110:  cond_true = (rs1_val < rs2_val);
      3'b111:  cond_true = (rs1_val >= rs2_val);
      default: cond_true = 1'b0;
    endcase
  end

  assign taken = (op_class == decode_pkg::op_jal) || (op_class == decode_pkg::op_jalr) ||
                 ((op_class == decode_pkg::op_branch) && cond_true);

  assign regwrite = (link.ins[11:7] != '0) &&
                    (op_class inside {decode_pkg::op_alu_reg, decode_pkg::op_alu_imm,
                                      decode_pkg::op_load, decode_pkg::op_jal,
                                      decode_pkg::op_jalr, decode_pkg::op_lui,
                                      decode_pkg::op_auipc});

  //////////////////////////////////////////////////////////////////////
  // ID/EX four-phase output
  //////////////////////////////////////////////////////////////////////

  assign link.ready = (state == decode_pkg::hs_idle);
  assign pop        = link.valid && link.ready;
  assign ex_req     = (state == decode_pkg::hs_wait_ack_high);

  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      state <= decode_pkg::hs_idle;
    end else begin
      unique case (state)
        decode_pkg::hs_idle:          if (pop) state <= decode_pkg::hs_wait_ack_high;
        decode_pkg::hs_wait_ack_high: if (ex_ack) state <= decode_pkg::hs_wait_ack_low;
        decode_pkg::hs_wait_ack_low:  if (!ex_ack) state <= decode_pkg::hs_idle;
        default:                      state <= decode_pkg::hs_idle;
      endcase
    end
  end

  // Bundle loads only on a pop
  always_ff @(posedge bus) begin
    if (pop) begin
      ex_op           <= op_class;
      ex_alu          <= alu_op;
      ex_rd           <= link.ins[11:7];
      ex_rs1_val      <= rs1_val;
      ex_rs2_val      <= rs2_val;
      ex_imm          <= imm;
      ex_pc           <= link.pc;
      ex_regwrite     <= regwrite;
      ex_branch_taken <= taken;
    end
  end

  a_bundle_hold : assert property (
    @(posedge bus) disable iff (!arst_n)
    (ex_req && !ex_ack) |=> $stable({ex_op, ex_alu, ex_rd, ex_rs1_val, ex_rs2_val,
                                     ex_imm, ex_pc, ex_regwrite, ex_branch_taken})
  );

endmodule

`default_nettype wire

// File: decode_subsys_top.sv
`default_nettype none

module decode_subsys_top (
  input  logic                                  bus,
  input  logic                                  arst_n,
  // Fetch side
  input  logic                                  fetch_req,
  input  logic [decode_pkg::pc_width-1:0]       fetch_pc,
  input  logic [31:0]                           fetch_ins,
  output logic                                  fetch_ack,
  // Execute side
  output logic                                  ex_req,
  input  logic                                  ex_ack,
  output decode_pkg::op_class_e                 ex_op,
  output decode_pkg::alu_op_e                   ex_alu,
  output logic [decode_pkg::reg_addr_width-1:0] ex_rd,
  output logic [decode_pkg::xlen-1:0]           ex_rs1_val,
  output logic [decode_pkg::xlen-1:0]           ex_rs2_val,
  output logic [decode_pkg::xlen-1:0]           ex_imm,
  output logic [decode_pkg::pc_width-1:0]       ex_pc,
  output logic                                  ex_regwrite,
  output logic                                  ex_branch_taken,
  // Write-back
  input  logic                                  wb_en,
  input  logic [decode_pkg::reg_addr_width-1:0] wb_rd,
  input  logic [decode_pkg::xlen-1:0]           wb_data
);

  if_id_if fetch_link ();
  if_id_if decode_link ();

  fetch_receiver rx_i (
    .bus       (bus),
    .arst_n    (arst_n),
    .fetch_req (fetch_req),
    .fetch_pc  (fetch_pc),
    .fetch_ins (fetch_ins),
    .fetch_ack (fetch_ack),
    .link      (fetch_link.src)
  );

  if_id_queue queue_i (
    .bus    (bus),
    .arst_n (arst_n),
    .wr     (fetch_link.dst),
    .rd     (decode_link.src)
  );

  decode_stage dec_i (
    .bus             (bus),
    .arst_n          (arst_n),
    .link            (decode_link.dst),
    .wb_en           (wb_en),
    .wb_rd           (wb_rd),
    .wb_data         (wb_data),
    .ex_req          (ex_req),
    .ex_ack          (ex_ack),
    .ex_op           (ex_op),
    .ex_alu          (ex_alu),
    .ex_rd           (ex_rd),
    .ex_rs1_val      (ex_rs1_val),
    .ex_rs2_val      (ex_rs2_val),
    .ex_imm          (ex_imm),
    .ex_pc           (ex_pc),
    .ex_regwrite     (ex_regwrite),
    .ex_branch_taken (ex_branch_taken)
  );

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
`default_nettype none

// Bus clock and power-on reset for the testbench
module tb_clock_gen (
  output logic bus,
  output logic arst_n
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int half_period = 10;
  localparam int reset_cycles = 3;

  initial begin
    bus = 1'b0;
    forever #(half_period) bus = ~bus;
  end

  // Release on a rising edge after three full cycles
  initial begin
    arst_n = 1'b0;
    repeat (reset_cycles) @(posedge bus);
    arst_n <= 1'b1;
  end

endmodule

`default_nettype wire

// File: tb_decode_subsys.sv
`default_nettype none

module tb_decode_subsys;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int wait_limit  = 200;
  localparam int total_words = 40;
  localparam int watchdog_ns = total_words * 200 + 20000;

  // Expected ID/EX bundle for one word
  typedef struct packed {
    decode_pkg::op_class_e op;
    decode_pkg::alu_op_e   alu;
    logic                  check_alu;
    logic [4:0]            rd;
    logic [31:0]           rs1_val;
    logic [31:0]           rs2_val;
    logic [31:0]           imm;
    logic                  check_imm;
    logic [15:0]           pc;
    logic                  regwrite;
    logic                  taken;
  } bundle_t;

  logic                  bus;
  logic                  arst_n;
  logic                  fetch_req;
  logic [15:0]           fetch_pc;
  logic [31:0]           fetch_ins;
  logic                  fetch_ack;
  logic                  ex_req;
  logic                  ex_ack;
  decode_pkg::op_class_e ex_op;
  decode_pkg::alu_op_e   ex_alu;
  logic [4:0]            ex_rd;
  logic [31:0]           ex_rs1_val;
  logic [31:0]           ex_rs2_val;
  logic [31:0]           ex_imm;
  logic [15:0]           ex_pc;
  logic                  ex_regwrite;
  logic                  ex_branch_taken;
  logic                  wb_en;
  logic [4:0]            wb_rd;
  logic [31:0]           wb_data;

  // Register file as the testbench expects it
  logic [31:0] shadow [32];
  bundle_t     expected [$];
  logic [15:0] pend_pc [$];
  logic [31:0] pend_ins [$];
  logic [31:0] pend_imm [$];
  integer      seed;
  int          error_count;
  int          check_count;
  int          accepted;

  tb_clock_gen clk_gen_i (
    .bus    (bus),
    .arst_n (arst_n)
  );

  decode_subsys_top dut_i (
    .bus             (bus),
    .arst_n          (arst_n),
    .fetch_req       (fetch_req),
    .fetch_pc        (fetch_pc),
    .fetch_ins       (fetch_ins),
    .fetch_ack       (fetch_ack),
    .ex_req          (ex_req),
    .ex_ack          (ex_ack),
    .ex_op           (ex_op),
    .ex_alu          (ex_alu),
    .ex_rd           (ex_rd),
    .ex_rs1_val      (ex_rs1_val),
    .ex_rs2_val      (ex_rs2_val),
    .ex_imm          (ex_imm),
    .ex_pc           (ex_pc),
    .ex_regwrite     (ex_regwrite),
    .ex_branch_taken (ex_branch_taken),
    .wb_en           (wb_en),
    .wb_rd           (wb_rd),
    .wb_data         (wb_data)
  );

  ////////////////////////////////////////////////////////////////////////
  // Instruction encoders
  ////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'h33};
  endfunction

  function automatic logic [31:0] i_type(input logic [31:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
    return {imm[11:0], rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] s_type(input logic [31:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] b_type(input logic [31:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic logic [31:0] u_type(input logic [31:0] imm, input logic [4:0] rd,
                                         input logic [6:0] opc);
    return {imm[31:12], rd, opc};
  endfunction

  function automatic logic [31:0] j_type(input logic [31:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
  endfunction

  ////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////

  function automatic decode_pkg::alu_op_e alu_expected(input logic [2:0] f3,
                                                       input logic alt);
    decode_pkg::alu_op_e op;
    case (f3)
      3'd0: op = alt ? decode_pkg::alu_sub : decode_pkg::alu_add;
      3'd1: op = decode_pkg::alu_sll;
      3'd2: op = decode_pkg::alu_slt;
      3'd3: op = decode_pkg::alu_sltu;
      3'd4: op = decode_pkg::alu_xor;
      3'd5: op = alt ? decode_pkg::alu_sra : decode_pkg::alu_srl;
      3'd6: op = decode_pkg::alu_or;
      default: op = decode_pkg::alu_and;
    endcase
    return op;
  endfunction

  function automatic logic branch_expected(input logic [2:0] f3, input logic [31:0] a,
                                           input logic [31:0] b);
    logic res;
    res = 1'b0;
    if (f3 == 3'd0) res = (a == b);
    if (f3 == 3'd1) res = (a != b);
    if (f3 == 3'd4) res = ($signed(a) < $signed(b));
    if (f3 == 3'd5) res = !($signed(a) < $signed(b));
    if (f3 == 3'd6) res = (a < b);
    if (f3 == 3'd7) res = !(a < b);
    return res;
  endfunction

  // imm is the value the word was encoded with
  function automatic bundle_t model_word(input logic [15:0] pc, input logic [31:0] ins,
                                         input logic [31:0] imm);
    bundle_t    e;
    logic [2:0] f3;
    f3 = ins[14:12];
    e = '0;
    e.op      = decode_pkg::op_illegal;
    e.alu     = decode_pkg::alu_add;
    e.rd      = ins[11:7];
    e.rs1_val = shadow[ins[19:15]];
    e.rs2_val = shadow[ins[24:20]];
    e.imm     = imm;
    e.pc      = pc;
    e.check_imm = 1'b1;
    case (ins[6:0])
      7'h33: begin
        e.op = decode_pkg::op_alu_reg;
        e.check_alu = 1'b1;
        e.check_imm = 1'b0;
        e.alu = alu_expected(f3, ins[30]);
      end
      7'h13: begin
        e.op = decode_pkg::op_alu_imm;
        e.check_alu = 1'b1;
        e.alu = alu_expected(f3, ins[30] && f3 == 3'd5);
      end
      7'h03: e.op = decode_pkg::op_load;
      7'h23: e.op = decode_pkg::op_store;
      7'h63: begin
        e.op = decode_pkg::op_branch;
        e.taken = branch_expected(f3, e.rs1_val, e.rs2_val);
      end
      7'h6f: begin
        e.op = decode_pkg::op_jal;
        e.taken = 1'b1;
      end
      7'h67: begin
        e.op = decode_pkg::op_jalr;
        e.taken = 1'b1;
      end
      7'h37: e.op = decode_pkg::op_lui;
      7'h17: e.op = decode_pkg::op_auipc;
      default: e.check_imm = 1'b0;
    endcase
    e.regwrite = (e.rd != 5'd0) && !(e.op inside {decode_pkg::op_store,
                 decode_pkg::op_branch, decode_pkg::op_illegal});
    return e;
  endfunction

  ////////////////////////////////////////////////////////////////////////
  // Fetch and execute side drivers
  ////////////////////////////////////////////////////////////////////////

  task automatic check_field(input string name, input logic [31:0] got,
                             input logic [31:0] want, input logic [15:0] pc);
    check_count++;
    if (got !== want) begin
      error_count++;
      $display("[ERROR] %s at pc %h: got %h, expected %h", name, pc, got, want);
    end
  endtask

  task automatic wait_fetch_ack(input logic level, output bit ok);
    ok = 1'b0;
    for (int i = 0; i < wait_limit && !ok; i++) begin
      @(posedge bus);
      ok = (fetch_ack === level);
    end
    if (!ok) begin
      error_count++;
      $display("fetch_ack did not go to %0b within %0d cycles", level, wait_limit);
    end
  endtask

  task automatic wait_ex_req(input logic level, output bit ok);
    ok = 1'b0;
    for (int i = 0; i < wait_limit && !ok; i++) begin
      @(posedge bus);
      ok = (ex_req === level);
    end
    if (!ok) begin
      error_count++;
      $display("ex_req did not go to %0b within %0d cycles", level, wait_limit);
    end
  endtask

  task automatic write_reg(input logic [4:0] rd, input logic [31:0] data);
    @(posedge bus);
    wb_en   <= 1'b1;
    wb_rd   <= rd;
    wb_data <= data;
    @(posedge bus);
    wb_en   <= 1'b0;
    if (rd != 5'd0) shadow[rd] = data;
  endtask

  task automatic add_word(input logic [15:0] pc, input logic [31:0] ins,
                          input logic [31:0] imm);
    pend_pc.push_back(pc);
    pend_ins.push_back(ins);
    pend_imm.push_back(imm);
  endtask

  task automatic fetch_word(input logic [15:0] pc, input logic [31:0] ins,
                            input logic [31:0] imm);
    bit ok;
    expected.push_back(model_word(pc, ins, imm));
    @(posedge bus);
    fetch_pc  <= pc;
    fetch_ins <= ins;
    fetch_req <= 1'b1;
    wait_fetch_ack(1'b1, ok);
    fetch_req <= 1'b0;
    if (ok) wait_fetch_ack(1'b0, ok);
    accepted++;
  endtask

  task automatic exec_word(input int delay);
    bundle_t e;
    bit      ok;
    wait_ex_req(1'b1, ok);
    if (!ok) return;
    if (expected.size() == 0) begin
      error_count++;
      $display("Unexpected word at the execute side with pc %h", ex_pc);
    end else begin
      e = expected.pop_front();
      check_field("ex_op", ex_op, e.op, e.pc);
      if (e.check_alu) check_field("ex_alu", ex_alu, e.alu, e.pc);
      check_field("ex_rd", ex_rd, e.rd, e.pc);
      check_field("ex_rs1_val", ex_rs1_val, e.rs1_val, e.pc);
      check_field("ex_rs2_val", ex_rs2_val, e.rs2_val, e.pc);
      if (e.check_imm) check_field("ex_imm", ex_imm, e.imm, e.pc);
      check_field("ex_pc", ex_pc, e.pc, e.pc);
      check_field("ex_regwrite", ex_regwrite, e.regwrite, e.pc);
      check_field("ex_branch_taken", ex_branch_taken, e.taken, e.pc);
    end
    repeat (delay) @(posedge bus);
    ex_ack <= 1'b1;
    wait_ex_req(1'b0, ok);
    ex_ack <= 1'b0;
  endtask

  // Sends the pending words; with hold set, ex_ack stays off until fetch stalls
  task automatic run_batch(input bit hold);
    int n;
    int base;
    n = pend_ins.size();
    base = accepted;
    fork
      begin
        for (int i = 0; i < n; i++) fetch_word(pend_pc[i], pend_ins[i], pend_imm[i]);
      end
      begin
        if (hold) begin
          for (int i = 0; i < wait_limit && accepted < base + 5; i++) @(posedge bus);
          repeat (10) @(posedge bus);
          check_count++;
          if (accepted != base + 5 || !fetch_req || fetch_ack) begin
            error_count++;
            $display("Fetch side did not stall on a full queue, %0d words accepted",
                     accepted - base);
          end
        end
        repeat (n) exec_word($unsigned($random(seed)) % 5);
      end
    join
    if (expected.size() != 0) begin
      error_count++;
      $display("%0d words never reached the execute side", expected.size());
      expected.delete();
    end
    pend_pc.delete();
    pend_ins.delete();
    pend_imm.delete();
  endtask

  ////////////////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////////////////

  task automatic test_reset();
    @(posedge bus);
    check_field("fetch_ack", fetch_ack, 32'd0, 16'h0000);
    check_field("ex_req", ex_req, 32'd0, 16'h0000);
    add_word(16'h0000, r_type(7'h00, 5'd2, 5'd1, 3'd0, 5'd3), 32'd0);
    run_batch(1'b0);
  endtask

  task automatic test_operands();
    for (int r = 0; r < 8; r++) write_reg(r[4:0], $random(seed));
    add_word(16'h0100, r_type(7'h00, 5'd2, 5'd1, 3'd0, 5'd5), 32'd0);
    add_word(16'h0104, r_type(7'h20, 5'd4, 5'd3, 3'd0, 5'd6), 32'd0);
    add_word(16'h0108, r_type(7'h20, 5'd6, 5'd5, 3'd5, 5'd7), 32'd0);
    add_word(16'h010c, r_type(7'h00, 5'd7, 5'd2, 3'd3, 5'd8), 32'd0);
    add_word(16'h0110, r_type(7'h00, 5'd2, 5'd0, 3'd7, 5'd0), 32'd0);
    add_word(16'h0114, i_type(32'hfffffffb, 5'd1, 3'd0, 5'd9, 7'h13), 32'hfffffffb);
    add_word(16'h0118, i_type(32'h00000403, 5'd2, 3'd5, 5'd10, 7'h13), 32'h00000403);
    add_word(16'h011c, i_type(32'h000007ff, 5'd0, 3'd4, 5'd11, 7'h13), 32'h000007ff);
    add_word(16'h0120, i_type(32'h00000001, 5'd3, 3'd6, 5'd0, 7'h13), 32'h00000001);
    run_batch(1'b0);
  endtask

  task automatic test_immediates();
    add_word(16'h0200, u_type(32'habcde000, 5'd12, 7'h37), 32'habcde000);
    add_word(16'h0204, u_type(32'h80001000, 5'd13, 7'h17), 32'h80001000);
    add_word(16'h0208, i_type(32'hfffffffc, 5'd1, 3'd2, 5'd14, 7'h03), 32'hfffffffc);
    add_word(16'h020c, s_type(32'h000007ff, 5'd2, 5'd3, 3'd2), 32'h000007ff);
    add_word(16'h0210, s_type(32'hfffff800, 5'd4, 5'd5, 3'd2), 32'hfffff800);
    add_word(16'h0214, j_type(32'hfffff800, 5'd1), 32'hfffff800);
    add_word(16'h0218, j_type(32'h00001234, 5'd0), 32'h00001234);
    add_word(16'h021c, i_type(32'h0000000c, 5'd6, 3'd0, 5'd15, 7'h67), 32'h0000000c);
    run_batch(1'b0);
  endtask

  task automatic test_branches();
    logic [31:0] back;
    logic [31:0] fwd;
    back = 32'hfffffff8;
    fwd  = 32'h00000010;
    // x16 and x17 equal, x18 negative, x19 larger positive
    write_reg(5'd16, 32'd5);
    write_reg(5'd17, 32'd5);
    write_reg(5'd18, 32'hfffffffd);
    write_reg(5'd19, 32'd7);
    add_word(16'h0300, b_type(back, 5'd17, 5'd16, 3'd0), back);
    add_word(16'h0304, b_type(fwd, 5'd19, 5'd16, 3'd0), fwd);
    add_word(16'h0308, b_type(back, 5'd19, 5'd16, 3'd1), back);
    add_word(16'h030c, b_type(fwd, 5'd17, 5'd16, 3'd1), fwd);
    add_word(16'h0310, b_type(back, 5'd16, 5'd18, 3'd4), back);
    add_word(16'h0314, b_type(fwd, 5'd18, 5'd16, 3'd4), fwd);
    add_word(16'h0318, b_type(back, 5'd18, 5'd16, 3'd5), back);
    add_word(16'h031c, b_type(fwd, 5'd16, 5'd18, 3'd5), fwd);
    add_word(16'h0320, b_type(back, 5'd18, 5'd16, 3'd6), back);
    add_word(16'h0324, b_type(fwd, 5'd16, 5'd18, 3'd6), fwd);
    add_word(16'h0328, b_type(back, 5'd16, 5'd18, 3'd7), back);
    add_word(16'h032c, b_type(fwd, 5'd19, 5'd16, 3'd7), fwd);
    add_word(16'h0330, j_type(fwd, 5'd0), fwd);
    add_word(16'h0334, i_type(back, 5'd18, 3'd0, 5'd0, 7'h67), back);
    run_batch(1'b0);
  endtask

  task automatic test_back_pressure();
    logic [31:0] imm;
    for (int i = 0; i < 6; i++) begin
      imm = i * 100 - 250;
      add_word(16'h0400 + i * 4, i_type(imm, i + 1, 3'd0, i + 20, 7'h13), imm);
    end
    run_batch(1'b1);
  endtask

  task automatic test_illegal();
    add_word(16'h0500, 32'hdeadbeff, 32'd0);
    add_word(16'h0504, 32'h00000f0b, 32'd0);
    run_batch(1'b0);
  endtask

  ////////////////////////////////////////////////////////////////////////
  // Sequence and watchdog
  ////////////////////////////////////////////////////////////////////////

  initial begin
    fetch_req   = 1'b0;
    fetch_pc    = '0;
    fetch_ins   = '0;
    ex_ack      = 1'b0;
    wb_en       = 1'b0;
    wb_rd       = '0;
    wb_data     = '0;
    seed        = 32'h63c202e5;
    error_count = 0;
    check_count = 0;
    accepted    = 0;
    for (int r = 0; r < 32; r++) shadow[r] = '0;
    @(posedge arst_n);
    test_reset();
    test_operands();
    test_immediates();
    test_branches();
    test_back_pressure();
    test_illegal();
    repeat (5) @(posedge bus);
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  initial begin
    #(watchdog_ns);
    $display("Watchdog expired after %0d ns, run stopped", watchdog_ns);
    $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
decode_pkg.sv
if_id_if.sv
fetch_receiver.sv
if_id_queue.sv
reg_file.sv
decode_stage.sv
decode_subsys_top.sv
tb_clock_gen.sv
tb_decode_subsys.sv

// File: Bender.yml
package:
  name: decode_subsys

sources:
  - decode_pkg.sv
  - if_id_if.sv
  - fetch_receiver.sv
  - if_id_queue.sv
  - reg_file.sv
  - decode_stage.sv
  - decode_subsys_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_decode_subsys.sv
